// File: clint_macros.svh
// CLINT bus and address map

`ifndef CLINT_MACROS_SVH
`define CLINT_MACROS_SVH

// bus widths
`define CLINT_ADDR_W 32
`define CLINT_DATA_W 32
`define CLINT_ID_W 4

// register bases
`define CLINT_MSIP_ADDR 32'h0200_0000
`define CLINT_MTIMECMP_ADDR 32'h0200_4000
`define CLINT_MTIME_ADDR 32'h0200_BFF8

`endif

// File: clint_pkg.sv
// CLINT shared types

package clint_pkg;

  typedef enum logic {
    RD_IDLE = 1'b0,
    RD_RESP = 1'b1
  } rd_state_e;

  typedef enum logic [1:0] {
    WR_IDLE = 2'd0,
    WR_DATA = 2'd1,
    WR_RESP = 2'd2
  } wr_state_e;

  // target of a decoded access
  typedef enum logic [1:0] {
    SEL_NONE     = 2'd0,
    SEL_MSIP     = 2'd1,
    SEL_MTIMECMP = 2'd2,
    SEL_MTIME    = 2'd3
  } reg_sel_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'd0,
    RESP_SLVERR = 2'd2
  } resp_e;

endpackage

// File: clint_reg_if.sv
// CLINT register access interface

`timescale 1ns/10ps

interface clint_reg_if;

  // write request from the bus side
  logic                 wr_en;
  clint_pkg::reg_sel_e  wr_sel;
  logic [7:0]           wr_mask;
  logic [63:0]          wr_data;

  // register state back to the bus side
  logic [63:0]          mtime_q;
  logic [63:0]          mtimecmp_q;
  logic                 msip_q;

  modport ctrl (
    output wr_en, wr_sel, wr_mask, wr_data,
    input  mtime_q, mtimecmp_q, msip_q
  );

  modport timer (
    input  wr_en, wr_sel, wr_mask, wr_data,
    output mtime_q, mtimecmp_q
  );

  modport swi (
    input  wr_en, wr_sel, wr_mask, wr_data,
    output msip_q
  );

endinterface

// File: clint_bus_ctrl.sv
// CLINT bus control and decode

`timescale 1ns/10ps

`include "clint_macros.svh"

module clint_bus_ctrl (
  input  logic                        clk,
  input  logic                        rst,

  input  logic                        aw_valid_i,
  output logic                        aw_ready_o,
  input  logic [`CLINT_ADDR_W-1:0]    aw_addr_i,
  input  logic [`CLINT_ID_W-1:0]      aw_id_i,
  input  logic [2:0]                  aw_size_i,

  input  logic                        w_valid_i,
  output logic                        w_ready_o,
  input  logic [`CLINT_DATA_W-1:0]    w_data_i,
  input  logic [`CLINT_DATA_W/8-1:0]  w_strb_i,

  output logic                        b_valid_o,
  input  logic                        b_ready_i,
  output logic [`CLINT_ID_W-1:0]      b_id_o,
  output logic [1:0]                  b_resp_o,

  input  logic                        ar_valid_i,
  output logic                        ar_ready_o,
  input  logic [`CLINT_ADDR_W-1:0]    ar_addr_i,
  input  logic [`CLINT_ID_W-1:0]      ar_id_i,
  input  logic [2:0]                  ar_size_i,

  output logic                        r_valid_o,
  input  logic                        r_ready_i,
  output logic [`CLINT_DATA_W-1:0]    r_data_o,
  output logic [`CLINT_ID_W-1:0]      r_id_o,
  output logic [1:0]                  r_resp_o,
  output logic                        r_last_o,

  clint_reg_if.ctrl                   reg_if
);

  localparam logic [`CLINT_ADDR_W-1:0] MSIP_BASE     = `CLINT_MSIP_ADDR;
  localparam logic [`CLINT_ADDR_W-1:0] MTIMECMP_BASE = `CLINT_MTIMECMP_ADDR;
  localparam logic [`CLINT_ADDR_W-1:0] MTIME_BASE    = `CLINT_MTIME_ADDR;

  clint_pkg::rd_state_e           rd_state;
  clint_pkg::wr_state_e           wr_state;
  clint_pkg::reg_sel_e            ar_sel;
  clint_pkg::reg_sel_e            wr_sel;
  logic                           ar_legal;
  logic                           wr_legal;
  logic [63:0]                    rd_val;
  logic [31:0]                    rd_shift;
  logic [`CLINT_DATA_W-1:0]       rd_data;
  logic [3:0]                     wr_lanes;
  logic [`CLINT_ADDR_W-1:0]       wr_addr_q;
  logic [`CLINT_ID_W-1:0]         wr_id_q;
  logic [2:0]                     wr_size_q;
  clint_pkg::resp_e               b_resp_q;
  logic [`CLINT_DATA_W-1:0]       r_data_q;
  logic [`CLINT_ID_W-1:0]         r_id_q;
  clint_pkg::resp_e               r_resp_q;

  function automatic clint_pkg::reg_sel_e decode_sel(input logic [`CLINT_ADDR_W-1:0] addr);
    clint_pkg::reg_sel_e sel;
    sel = clint_pkg::SEL_NONE;
    if (addr[`CLINT_ADDR_W-1:2] == MSIP_BASE[`CLINT_ADDR_W-1:2])
      sel = clint_pkg::SEL_MSIP;
    else if (addr[`CLINT_ADDR_W-1:3] == MTIMECMP_BASE[`CLINT_ADDR_W-1:3])
      sel = clint_pkg::SEL_MTIMECMP;
    else if (addr[`CLINT_ADDR_W-1:3] == MTIME_BASE[`CLINT_ADDR_W-1:3])
      sel = clint_pkg::SEL_MTIME;
    return sel;
  endfunction

  // access must stay inside its 32-bit word
  function automatic logic access_ok(input logic [2:0] size, input logic [1:0] offs);
    case (size)
      3'd0:    return 1'b1;
      3'd1:    return offs != 2'd3;
      3'd2:    return offs == 2'd0;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [3:0] size_lanes(input logic [2:0] size);
    case (size)
      3'd0:    return 4'b0001;
      3'd1:    return 4'b0011;
      3'd2:    return 4'b1111;
      default: return 4'b0000;
    endcase
  endfunction

  // read path
  assign ar_ready_o = (rd_state == clint_pkg::RD_IDLE) && ar_valid_i;
  assign ar_sel     = decode_sel(ar_addr_i);
  assign ar_legal   = (ar_sel != clint_pkg::SEL_NONE) && access_ok(ar_size_i, ar_addr_i[1:0]);

  always_comb begin
    case (ar_sel)
      clint_pkg::SEL_MSIP:     rd_val = {63'd0, reg_if.msip_q};
      clint_pkg::SEL_MTIMECMP: rd_val = reg_if.mtimecmp_q;
      clint_pkg::SEL_MTIME:    rd_val = reg_if.mtime_q;
      default:                 rd_val = 64'd0;
    endcase
    rd_shift = (ar_addr_i[2] ? rd_val[63:32] : rd_val[31:0]) >> {ar_addr_i[1:0], 3'b000};
    // replicate across the bus for narrow reads
    case (ar_size_i)
      3'd0:    rd_data = {4{rd_shift[7:0]}};
      3'd1:    rd_data = {2{rd_shift[15:0]}};
      default: rd_data = rd_shift;
    endcase
    if (!ar_legal)
      rd_data = '0;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_state <= clint_pkg::RD_IDLE;
    end else begin
      case (rd_state)
        clint_pkg::RD_IDLE: if (ar_valid_i && ar_ready_o) rd_state <= clint_pkg::RD_RESP;
        clint_pkg::RD_RESP: if (r_valid_o && r_ready_i) rd_state <= clint_pkg::RD_IDLE;
        default:            rd_state <= clint_pkg::RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (ar_valid_i && ar_ready_o) begin
      r_data_q <= rd_data;
      r_id_q   <= ar_id_i;
      r_resp_q <= ar_legal ? clint_pkg::RESP_OKAY : clint_pkg::RESP_SLVERR;
    end
  end

  assign r_valid_o = rd_state == clint_pkg::RD_RESP;
  assign r_last_o  = r_valid_o;
  assign r_data_o  = r_data_q;
  assign r_id_o    = r_id_q;
  assign r_resp_o  = r_resp_q;

  // write path
  assign aw_ready_o = (wr_state == clint_pkg::WR_IDLE) && aw_valid_i;
  assign w_ready_o  = (wr_state == clint_pkg::WR_DATA) && w_valid_i;
  assign wr_sel     = decode_sel(wr_addr_q);
  assign wr_legal   = (wr_sel != clint_pkg::SEL_NONE) && access_ok(wr_size_q, wr_addr_q[1:0]);
  assign wr_lanes   = w_strb_i & (size_lanes(wr_size_q) << wr_addr_q[1:0]);

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_state <= clint_pkg::WR_IDLE;
    end else begin
      case (wr_state)
        clint_pkg::WR_IDLE: if (aw_valid_i && aw_ready_o) wr_state <= clint_pkg::WR_DATA;
        clint_pkg::WR_DATA: if (w_valid_i && w_ready_o) wr_state <= clint_pkg::WR_RESP;
        clint_pkg::WR_RESP: if (b_valid_o && b_ready_i) wr_state <= clint_pkg::WR_IDLE;
        default:            wr_state <= clint_pkg::WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (aw_valid_i && aw_ready_o) begin
      wr_addr_q <= aw_addr_i;
      wr_id_q   <= aw_id_i;
      wr_size_q <= aw_size_i;
    end
    if (w_valid_i && w_ready_o)
      b_resp_q <= wr_legal ? clint_pkg::RESP_OKAY : clint_pkg::RESP_SLVERR;
  end

  // word goes into the half picked by address bit 2
  assign reg_if.wr_en   = w_valid_i && w_ready_o && wr_legal;
  assign reg_if.wr_sel  = wr_sel;
  assign reg_if.wr_mask = wr_addr_q[2] ? {wr_lanes, 4'b0000} : {4'b0000, wr_lanes};
  assign reg_if.wr_data = wr_addr_q[2] ? {w_data_i, 32'd0} : {32'd0, w_data_i};

  assign b_valid_o = wr_state == clint_pkg::WR_RESP;
  assign b_id_o    = wr_id_q;
  assign b_resp_o  = b_resp_q;

endmodule

// File: clint_timer.sv
// CLINT machine timer

`timescale 1ns/10ps

module clint_timer (
  input  logic        clk,
  input  logic        rst,
  clint_reg_if.timer  reg_if,
  output logic        timer_irq_o
);

  logic [63:0] mtime_q;
  logic [63:0] mtimecmp_q;
  logic        mtime_wr;
  logic        mtimecmp_wr;

  // byte-masked merge over the 64-bit view
  function automatic logic [63:0] merge(
    input logic [63:0] old_v,
    input logic [63:0] new_v,
    input logic [7:0]  mask
  );
    logic [63:0] bits;
    for (int i = 0; i < 8; i++)
      bits[8*i +: 8] = {8{mask[i]}};
    return (old_v & ~bits) | (new_v & bits);
  endfunction

  assign mtime_wr    = reg_if.wr_en && (reg_if.wr_sel == clint_pkg::SEL_MTIME);
  assign mtimecmp_wr = reg_if.wr_en && (reg_if.wr_sel == clint_pkg::SEL_MTIMECMP);

  // a write replaces that cycle's increment
  always_ff @(posedge clk) begin
    if (rst)
      mtime_q <= 64'd0;
    else if (mtime_wr)
      mtime_q <= merge(mtime_q, reg_if.wr_data, reg_if.wr_mask);
    else
      mtime_q <= mtime_q + 64'd1;
  end

  always_ff @(posedge clk) begin
    if (rst)
      mtimecmp_q <= 64'd0;
    else if (mtimecmp_wr)
      mtimecmp_q <= merge(mtimecmp_q, reg_if.wr_data, reg_if.wr_mask);
  end

  assign reg_if.mtime_q    = mtime_q;
  assign reg_if.mtimecmp_q = mtimecmp_q;

  // unsigned compare
  assign timer_irq_o = mtime_q >= mtimecmp_q;

endmodule

// File: clint_swi.sv
// CLINT software interrupt

`timescale 1ns/10ps

module clint_swi (
  input  logic      clk,
  input  logic      rst,
  clint_reg_if.swi  reg_if,
  output logic      soft_irq_o
);

  logic msip_q;
  logic msip_wr;

  // only lane 0 of the low word reaches the msip bit
  assign msip_wr = reg_if.wr_en && (reg_if.wr_sel == clint_pkg::SEL_MSIP) && reg_if.wr_mask[0];

  always_ff @(posedge clk) begin
    if (rst)
      msip_q <= 1'b0;
    else if (msip_wr)
      msip_q <= reg_if.wr_data[0];
  end

  assign reg_if.msip_q = msip_q;
  assign soft_irq_o    = msip_q;

endmodule

// File: clint_top.sv
// CLINT top level

`timescale 1ns/10ps

`include "clint_macros.svh"

module clint_top (
  input  logic                        clk,
  input  logic                        rst,

  input  logic                        aw_valid_i,
  output logic                        aw_ready_o,
  input  logic [`CLINT_ADDR_W-1:0]    aw_addr_i,
  input  logic [`CLINT_ID_W-1:0]      aw_id_i,
  input  logic [2:0]                  aw_size_i,

  input  logic                        w_valid_i,
  output logic                        w_ready_o,
  input  logic [`CLINT_DATA_W-1:0]    w_data_i,
  input  logic [`CLINT_DATA_W/8-1:0]  w_strb_i,

  output logic                        b_valid_o,
  input  logic                        b_ready_i,
  output logic [`CLINT_ID_W-1:0]      b_id_o,
  output logic [1:0]                  b_resp_o,

  input  logic                        ar_valid_i,
  output logic                        ar_ready_o,
  input  logic [`CLINT_ADDR_W-1:0]    ar_addr_i,
  input  logic [`CLINT_ID_W-1:0]      ar_id_i,
  input  logic [2:0]                  ar_size_i,

  output logic                        r_valid_o,
  input  logic                        r_ready_i,
  output logic [`CLINT_DATA_W-1:0]    r_data_o,
  output logic [`CLINT_ID_W-1:0]      r_id_o,
  output logic [1:0]                  r_resp_o,
  output logic                        r_last_o,

  output logic                        soft_irq_o,
  output logic                        timer_irq_o
);

  clint_reg_if reg_if ();

  // bus side, the only address decoder
  clint_bus_ctrl u_bus_ctrl (
    .clk        (clk),
    .rst        (rst),
    .aw_valid_i (aw_valid_i),
    .aw_ready_o (aw_ready_o),
    .aw_addr_i  (aw_addr_i),
    .aw_id_i    (aw_id_i),
    .aw_size_i  (aw_size_i),
    .w_valid_i  (w_valid_i),
    .w_ready_o  (w_ready_o),
    .w_data_i   (w_data_i),
    .w_strb_i   (w_strb_i),
    .b_valid_o  (b_valid_o),
    .b_ready_i  (b_ready_i),
    .b_id_o     (b_id_o),
    .b_resp_o   (b_resp_o),
    .ar_valid_i (ar_valid_i),
    .ar_ready_o (ar_ready_o),
    .ar_addr_i  (ar_addr_i),
    .ar_id_i    (ar_id_i),
    .ar_size_i  (ar_size_i),
    .r_valid_o  (r_valid_o),
    .r_ready_i  (r_ready_i),
    .r_data_o   (r_data_o),
    .r_id_o     (r_id_o),
    .r_resp_o   (r_resp_o),
    .r_last_o   (r_last_o),
    .reg_if     (reg_if.ctrl)
  );

  clint_timer u_timer (
    .clk         (clk),
    .rst         (rst),
    .reg_if      (reg_if.timer),
    .timer_irq_o (timer_irq_o)
  );

  clint_swi u_swi (
    .clk        (clk),
    .rst        (rst),
    .reg_if     (reg_if.swi),
    .soft_irq_o (soft_irq_o)
  );

endmodule

// File: clint_asserts.sv
// CLINT bus handshake assertions

`timescale 1ns/10ps

`include "clint_macros.svh"

module clint_asserts (
  input logic                      clk,
  input logic                      rst,
  input logic                      aw_ready_i,
  input clint_pkg::wr_state_e      wr_state_i,
  input logic                      b_valid_i,
  input logic                      b_ready_i,
  input logic                      r_valid_i,
  input logic                      r_ready_i,
  input logic [`CLINT_DATA_W-1:0]  r_data_i
);

  int unsigned fails = 0;

  // read response held with stable data
  r_hold: assert property (@(posedge clk) disable iff (rst)
    r_valid_i && !r_ready_i |=> r_valid_i && $stable(r_data_i))
    else begin
      fails++;
      $error("read response dropped or changed before it was accepted");
    end

  b_hold: assert property (@(posedge clk) disable iff (rst)
    b_valid_i && !b_ready_i |=> b_valid_i)
    else begin
      fails++;
      $error("write response dropped before it was accepted");
    end

  aw_idle: assert property (@(posedge clk) disable iff (rst)
    aw_ready_i |-> wr_state_i == clint_pkg::WR_IDLE)
    else begin
      fails++;
      $error("aw_ready high while the write FSM is busy");
    end

  // no response right after reset
  rst_quiet: assert property (@(posedge clk) rst |=> !r_valid_i && !b_valid_i)
    else begin
      fails++;
      $error("response valid high in the cycle after reset");
    end

endmodule

// File: tb_clint.sv
// CLINT testbench

`timescale 1ns/10ps

`include "clint_macros.svh"

module tb_clint;

  localparam int TMO = 64;

  logic                        clk;
  logic                        rst;
  logic                        aw_valid_i;
  logic                        aw_ready_o;
  logic [`CLINT_ADDR_W-1:0]    aw_addr_i;
  logic [`CLINT_ID_W-1:0]      aw_id_i;
  logic [2:0]                  aw_size_i;
  logic                        w_valid_i;
  logic                        w_ready_o;
  logic [`CLINT_DATA_W-1:0]    w_data_i;
  logic [`CLINT_DATA_W/8-1:0]  w_strb_i;
  logic                        b_valid_o;
  logic                        b_ready_i;
  logic [`CLINT_ID_W-1:0]      b_id_o;
  logic [1:0]                  b_resp_o;
  logic                        ar_valid_i;
  logic                        ar_ready_o;
  logic [`CLINT_ADDR_W-1:0]    ar_addr_i;
  logic [`CLINT_ID_W-1:0]      ar_id_i;
  logic [2:0]                  ar_size_i;
  logic                        r_valid_o;
  logic                        r_ready_i;
  logic [`CLINT_DATA_W-1:0]    r_data_o;
  logic [`CLINT_ID_W-1:0]      r_id_o;
  logic [1:0]                  r_resp_o;
  logic                        r_last_o;
  logic                        soft_irq_o;
  logic                        timer_irq_o;

  // reference registers and the write in flight
  logic [63:0]                 m_mtime;
  logic [63:0]                 m_mtimecmp;
  logic                        m_msip;
  clint_pkg::reg_sel_e         pend_sel;
  logic                        pend_ok;
  logic [7:0]                  pend_mask;
  logic [63:0]                 pend_data;
  logic [31:0]                 lcg_state;
  int                          errors;
  int                          checks;

  clint_top dut0 (.*);

  bind clint_bus_ctrl clint_asserts u_asserts (
    .clk        (clk),
    .rst        (rst),
    .aw_ready_i (aw_ready_o),
    .wr_state_i (wr_state),
    .b_valid_i  (b_valid_o),
    .b_ready_i  (b_ready_i),
    .r_valid_i  (r_valid_o),
    .r_ready_i  (r_ready_i),
    .r_data_i   (r_data_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
  endfunction

  function automatic logic [63:0] merge_bytes(input logic [63:0] old_v,
                                              input logic [63:0] new_v,
                                              input logic [7:0] mask);
    logic [63:0] res;
    res = old_v;
    for (int i = 0; i < 8; i++)
      if (mask[i])
        res[8*i +: 8] = new_v[8*i +: 8];
    return res;
  endfunction

  // legal when mapped, at most a word, and not crossing the word end
  function automatic logic access_legal(input clint_pkg::reg_sel_e sel,
                                        input logic [1:0] offs, input logic [2:0] size);
    if (sel == clint_pkg::SEL_NONE || size > 3'd2)
      return 1'b0;
    return (int'(offs) + (1 << size)) <= 4;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL at %0t: %s expected %0h got %0h", $time, name, exp, got);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    $display("ERROR at %0t: timed out waiting for %s", $time, what);
  endtask

  // mtime counts every cycle unless written
  always @(posedge clk) begin
    if (rst) begin
      m_mtime    <= 64'd0;
      m_mtimecmp <= 64'd0;
      m_msip     <= 1'b0;
    end else begin
      check_value("timer_irq_o", timer_irq_o, m_mtime >= m_mtimecmp);
      check_value("soft_irq_o", soft_irq_o, m_msip);
      if (w_valid_i && w_ready_o && pend_ok && pend_sel == clint_pkg::SEL_MTIME)
        m_mtime <= merge_bytes(m_mtime, pend_data, pend_mask);
      else
        m_mtime <= m_mtime + 64'd1;
      if (w_valid_i && w_ready_o && pend_ok && pend_sel == clint_pkg::SEL_MTIMECMP)
        m_mtimecmp <= merge_bytes(m_mtimecmp, pend_data, pend_mask);
      if (w_valid_i && w_ready_o && pend_ok && pend_sel == clint_pkg::SEL_MSIP && pend_mask[0])
        m_msip <= pend_data[0];
    end
  end

  task automatic pick_access(output logic [31:0] addr, output clint_pkg::reg_sel_e sel,
                             output logic [2:0] size);
    int kind;
    int sz;
    kind = next_rand() % 7;
    sz   = next_rand() % 8;
    case (kind)
      0:       addr = `CLINT_MSIP_ADDR;
      1:       addr = `CLINT_MTIMECMP_ADDR;
      2:       addr = `CLINT_MTIMECMP_ADDR + 32'd4;
      3:       addr = `CLINT_MTIME_ADDR;
      4:       addr = `CLINT_MTIME_ADDR + 32'd4;
      5:       addr = `CLINT_MSIP_ADDR + 32'd4;
      default: addr = 32'h0200_1000;
    endcase
    case (kind)
      0:       sel = clint_pkg::SEL_MSIP;
      1, 2:    sel = clint_pkg::SEL_MTIMECMP;
      3, 4:    sel = clint_pkg::SEL_MTIME;
      default: sel = clint_pkg::SEL_NONE;
    endcase
    if (next_rand() % 2)
      addr[1:0] = 2'(next_rand());
    size = (sz < 6) ? 3'(sz % 3) : 3'(sz - 3);
  endtask

  task automatic write_reg(input logic [31:0] addr, input clint_pkg::reg_sel_e sel,
                           input logic [2:0] size, input logic [31:0] data,
                           input logic [3:0] strb);
    logic [3:0] lanes;
    logic [3:0] id;
    logic       got;
    int         dly;
    int         t;
    id    = 4'(next_rand());
    dly   = next_rand() % 4;
    lanes = 4'd0;
    for (int i = 0; i < 4; i++)
      if (size <= 3'd2 && i >= addr[1:0] && i < addr[1:0] + (1 << size))
        lanes[i] = strb[i];
    @(posedge clk);
    pend_sel   = sel;
    pend_ok    = access_legal(sel, addr[1:0], size);
    pend_mask  = addr[2] ? {lanes, 4'd0} : {4'd0, lanes};
    pend_data  = addr[2] ? {data, 32'd0} : {32'd0, data};
    aw_valid_i <= 1'b1;
    aw_addr_i  <= addr;
    aw_id_i    <= id;
    aw_size_i  <= size;
    t = 0;
    do begin
      @(posedge clk);
      t++;
      got = aw_ready_o;
    end while (!got && t < TMO);
    aw_valid_i <= 1'b0;
    if (!got)
      report_timeout("aw_ready_o");
    w_valid_i <= 1'b1;
    w_data_i  <= data;
    w_strb_i  <= strb;
    t = 0;
    do begin
      @(posedge clk);
      t++;
      got = w_ready_o;
    end while (!got && t < TMO);
    w_valid_i <= 1'b0;
    if (!got)
      report_timeout("w_ready_o");
    t = 0;
    do begin
      @(posedge clk);
      t++;
      got = b_valid_o && b_ready_i;
      if (t > dly)
        b_ready_i <= 1'b1;
    end while (!got && t < TMO);
    b_ready_i <= 1'b0;
    if (!got) begin
      report_timeout("the write response");
    end else begin
      check_value("b_id_o", b_id_o, id);
      check_value("b_resp_o", b_resp_o,
                  pend_ok ? clint_pkg::RESP_OKAY : clint_pkg::RESP_SLVERR);
    end
  endtask

  task automatic read_reg(input logic [31:0] addr, input clint_pkg::reg_sel_e sel,
                          input logic [2:0] size);
    logic [63:0] val;
    logic [31:0] word;
    logic [31:0] exp_data;
    logic [3:0]  id;
    logic        legal;
    logic        got;
    int          dly;
    int          t;
    id    = 4'(next_rand());
    dly   = next_rand() % 4;
    legal = access_legal(sel, addr[1:0], size);
    @(posedge clk);
    ar_valid_i <= 1'b1;
    ar_addr_i  <= addr;
    ar_id_i    <= id;
    ar_size_i  <= size;
    t = 0;
    do begin
      @(posedge clk);
      t++;
      got = ar_ready_o;
    end while (!got && t < TMO);
    ar_valid_i <= 1'b0;
    if (!got)
      report_timeout("ar_ready_o");
    // model values here are still the ones from before this edge
    case (sel)
      clint_pkg::SEL_MSIP:     val = {63'd0, m_msip};
      clint_pkg::SEL_MTIMECMP: val = m_mtimecmp;
      clint_pkg::SEL_MTIME:    val = m_mtime;
      default:                 val = 64'd0;
    endcase
    word = (addr[2] ? val[63:32] : val[31:0]) >> (8 * addr[1:0]);
    case (size)
      3'd0:    exp_data = {4{word[7:0]}};
      3'd1:    exp_data = {2{word[15:0]}};
      default: exp_data = word;
    endcase
    if (!legal)
      exp_data = 32'd0;
    t = 0;
    do begin
      @(posedge clk);
      t++;
      got = r_valid_o && r_ready_i;
      if (t > dly)
        r_ready_i <= 1'b1;
    end while (!got && t < TMO);
    r_ready_i <= 1'b0;
    if (!got) begin
      report_timeout("the read response");
    end else begin
      check_value("r_data_o", r_data_o, exp_data);
      check_value("r_id_o", r_id_o, id);
      check_value("r_last_o", r_last_o, 1'b1);
      check_value("r_resp_o", r_resp_o,
                  legal ? clint_pkg::RESP_OKAY : clint_pkg::RESP_SLVERR);
    end
  endtask

  initial begin
    logic [31:0]         addr;
    clint_pkg::reg_sel_e sel;
    logic [2:0]          size;
    logic [31:0]         data;
    logic [3:0]          strb;
    int                  afails;
    rst        = 1'b1;
    aw_valid_i = 1'b0;
    aw_addr_i  = '0;
    aw_id_i    = '0;
    aw_size_i  = '0;
    w_valid_i  = 1'b0;
    w_data_i   = '0;
    w_strb_i   = '0;
    b_ready_i  = 1'b0;
    ar_valid_i = 1'b0;
    ar_addr_i  = '0;
    ar_id_i    = '0;
    ar_size_i  = '0;
    r_ready_i  = 1'b0;
    pend_sel   = clint_pkg::SEL_NONE;
    pend_ok    = 1'b0;
    pend_mask  = 8'd0;
    pend_data  = 64'd0;
    lcg_state  = 32'd61654;
    errors     = 0;
    checks     = 0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    // mixed traffic, every write read back at once
    for (int n = 0; n < 300; n++) begin
      pick_access(addr, sel, size);
      if (next_rand() % 2) begin
        data = (next_rand() << 16) | next_rand();
        strb = (next_rand() % 4 == 0) ? 4'(next_rand()) : 4'hF;
        write_reg(addr, sel, size, data, strb);
      end
      read_reg(addr, sel, size);
      repeat (next_rand() % 5) @(posedge clk);
    end
    // compare value placed a few ticks ahead of mtime
    for (int n = 0; n < 6; n++) begin
      write_reg(`CLINT_MTIMECMP_ADDR + 32'd4, clint_pkg::SEL_MTIMECMP, 3'd2,
                m_mtime[63:32], 4'hF);
      write_reg(`CLINT_MTIMECMP_ADDR, clint_pkg::SEL_MTIMECMP, 3'd2,
                m_mtime[31:0] + 32'd12 + 32'(next_rand() % 16), 4'hF);
      repeat (40) @(posedge clk);
    end
    afails = dut0.u_bus_ctrl.u_asserts.fails;
    $display("checks: %0d  errors: %0d  assertion failures: %0d", checks, errors, afails);
    if (errors == 0 && afails == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

// File: tb.f
+incdir+.
clint_pkg.sv
clint_reg_if.sv
clint_bus_ctrl.sv
clint_timer.sv
clint_swi.sv
clint_top.sv
clint_asserts.sv
tb_clint.sv
